// File: sources.f
mera_pkg.sv
puks.sv
panel_ctl.sv
bus_master.sv
mem_ram.sv
mera_sys.sv
tb_checker.sv
tb_mera_sys.sv

// File: run.sh
#!/bin/sh
# build and run the mera_sys testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mera_sys -f sources.f -o tb_mera_sys
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_mera_sys > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Testbench passed$" sim.log; then
	exit 0
fi
exit 1

// File: tb_mera_sys.sv
// --------------------
// testbench for the mera-400 system top
// clock, reset, DUT, watcher and a table of
// panel commands applied one row at a time
// --------------------

`timescale 1ns/10ps

module tb_mera_sys;

	import mera_pkg::*;

	// what a wait loop is waiting for
	localparam int WAIT_READY = 0;
	localparam int WAIT_BUSY = 1;
	localparam int WAIT_DONE = 2;
	localparam int WAIT_LIMIT = 64;

	typedef struct packed {
		panel_cmd_t cmd;
		word_t kl;
		nb_t kl_nb;
		// also strobe a load_ar while this row is busy
		logic drop;
	} step_t;

	localparam int NSTEPS = 18;

	step_t steps [NSTEPS] = '{
		// first store lands at 0:0, so an early strobe would show here
		'{cmd_store, 16'h1111, 4'h0, 1'b0},
		'{cmd_load_ar, 16'h0010, 4'h0, 1'b0},
		'{cmd_store, 16'ha5a5, 4'h0, 1'b0},
		'{cmd_store, 16'h5a5a, 4'h0, 1'b1},
		'{cmd_store, 16'h0f0f, 4'h0, 1'b0},
		// read back
		'{cmd_load_ar, 16'h0010, 4'h0, 1'b0},
		'{cmd_fetch, 16'h0000, 4'h0, 1'b0},
		'{cmd_fetch, 16'h0000, 4'h0, 1'b0},
		'{cmd_fetch, 16'h0000, 4'h0, 1'b0},
		// absent memory, above the top and outside segment 0
		'{cmd_load_ar, 16'h0800, 4'h0, 1'b0},
		'{cmd_fetch, 16'h0000, 4'h0, 1'b0},
		'{cmd_load_ar, 16'h0005, 4'h3, 1'b0},
		'{cmd_fetch, 16'h0000, 4'h0, 1'b0},
		// clear, then memory must still be there
		'{cmd_clear, 16'h0000, 4'h0, 1'b0},
		'{cmd_fetch, 16'h0000, 4'h0, 1'b0},
		'{cmd_load_ar, 16'h0011, 4'h0, 1'b0},
		'{cmd_fetch, 16'h0000, 4'h0, 1'b1},
		'{cmd_fetch, 16'h0000, 4'h0, 1'b0}
	};

	logic clk_ext;
	logic rst_n;
	logic cmd_stb;
	panel_cmd_t cmd;
	word_t kl;
	nb_t kl_nb;
	word_t w;
	addr_t ar;
	nb_t nb;
	logic busy;
	logic done;
	logic alarm;
	logic pon;
	int err_cnt;
	int timeouts;
	logic ok;
	logic hung;

	mera_sys mera_sys_i (
		.clk_ext(clk_ext),
		.rst_n(rst_n),
		.cmd_stb(cmd_stb),
		.cmd(cmd),
		.kl(kl),
		.kl_nb(kl_nb),
		.w(w),
		.ar(ar),
		.nb(nb),
		.busy(busy),
		.done(done),
		.alarm(alarm),
		.pon(pon)
	);

	tb_checker checker_i (
		.clk_ext(clk_ext),
		.rst_n(rst_n),
		.cmd_stb(cmd_stb),
		.cmd(cmd),
		.kl(kl),
		.kl_nb(kl_nb),
		.w(w),
		.ar(ar),
		.nb(nb),
		.busy(busy),
		.done(done),
		.alarm(alarm),
		.pon(pon),
		.err_cnt(err_cnt)
	);

	// 40 ns clock
	always #20 clk_ext = ~clk_ext;

// --------------------
// helpers
// --------------------

	// one-cycle command strobe
	task automatic issue_cmd(input panel_cmd_t c, input word_t k, input nb_t n);
		@(posedge clk_ext);
		cmd_stb <= 1'b1;
		cmd <= c;
		kl <= k;
		kl_nb <= n;
		@(posedge clk_ext);
		cmd_stb <= 1'b0;
	endtask

	// polls at the falling edge, gives up after WAIT_LIMIT cycles
	task automatic wait_for(input int what, input string name, output logic hit);
		int n;
		hit = 1'b0;
		n = 0;
		while (!hit && n < WAIT_LIMIT) begin
			@(negedge clk_ext);
			case (what)
				WAIT_READY: hit = pon && !busy;
				WAIT_BUSY: hit = busy;
				default: hit = done;
			endcase
			n++;
		end
		if (!hit) begin
			$display("timeout after %0d cycles while waiting for %s", WAIT_LIMIT, name);
			timeouts++;
		end
	endtask

// --------------------
// stimulus
// --------------------

	initial begin
		clk_ext = 1'b0;
		rst_n = 1'b0;
		cmd_stb = 1'b0;
		cmd = cmd_load_ar;
		kl = '0;
		kl_nb = '0;
		timeouts = 0;
		ok = 1'b1;
		hung = 1'b0;
		repeat (2) @(posedge clk_ext);
		rst_n <= 1'b1;
		// strobe during the power-on hold, must be ignored
		issue_cmd(cmd_load_ar, 16'h1234, 4'h0);
		for (int i = 0; i < NSTEPS; i++) begin
			if (!hung) begin
				wait_for(WAIT_READY, "pon high and busy low", ok);
				if (ok) begin
					issue_cmd(steps[i].cmd, steps[i].kl, steps[i].kl_nb);
					if (steps[i].drop) begin
						wait_for(WAIT_BUSY, "busy high", ok);
						if (ok)
							issue_cmd(cmd_load_ar, 16'hffff, 4'hf);
					end
					if (ok)
						wait_for(WAIT_DONE, "done", ok);
				end
				if (!ok)
					hung = 1'b1;
			end
		end
		repeat (2) @(posedge clk_ext);
		$display("errors: %0d compare, %0d timeout", err_cnt, timeouts);
		if (err_cnt == 0 && !hung)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: tb_checker.sv
// --------------------
// testbench watcher for the mera-400 slice
// tracks accepted panel commands in its own model
// of memory, ar, nb, w, alarm, busy and pon
// --------------------

`timescale 1ns/10ps

module tb_checker (
	input logic clk_ext,
	input logic rst_n,
	input logic cmd_stb,
	input mera_pkg::panel_cmd_t cmd,
	input mera_pkg::word_t kl,
	input mera_pkg::nb_t kl_nb,
	input mera_pkg::word_t w,
	input mera_pkg::addr_t ar,
	input mera_pkg::nb_t nb,
	input logic busy,
	input logic done,
	input logic alarm,
	input logic pon,
	output int err_cnt
);

	import mera_pkg::*;

	// reference state
	word_t mem_m [MEM_WORDS];
	word_t w_m;
	addr_t ar_m;
	nb_t nb_m;
	logic alarm_m;
	// a command is in progress in the model
	logic pending;
	// clock edges seen since reset release
	int pon_cnt;

	initial err_cnt = 0;

	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got %h expected %h", name, got, exp);
			err_cnt++;
		end
	endtask

// --------------------
// model update
// --------------------

	task automatic apply_cmd();
		logic present;
		logic [MEM_AW-1:0] idx;
		// only segment 0 below MEM_WORDS answers
		present = (nb_m == '0) && (ar_m < addr_t'(MEM_WORDS));
		idx = ar_m[16-MEM_AW:15];
		case (cmd)
			cmd_load_ar: begin
				ar_m = kl;
				nb_m = kl_nb;
			end
			cmd_store, cmd_fetch: begin
				if (!present) begin
					// fault keeps w and ar
					alarm_m = 1'b1;
				end else begin
					if (cmd == cmd_store)
						mem_m[idx] = kl;
					else
						w_m = mem_m[idx];
					ar_m = ar_m + addr_t'(1);
				end
			end
			default: begin
				// clear keeps w and memory
				ar_m = '0;
				nb_m = '0;
				alarm_m = 1'b0;
			end
		endcase
	endtask

	// sampled mid-cycle, away from the driving edge
	always @(negedge clk_ext) begin
		logic pon_m;
		if (!rst_n) begin
			w_m = '0;
			ar_m = '0;
			nb_m = '0;
			alarm_m = 1'b0;
			pending = 1'b0;
			pon_cnt = 0;
		end else begin
			// pon is up PON_TICKS edges after release
			pon_m = (pon_cnt >= PON_TICKS);
			compare("pon", {15'h0000, pon}, {15'h0000, pon_m});
			if (pon_cnt < PON_TICKS)
				pon_cnt++;
			// busy covers an accepted command up to its done
			compare("busy", {15'h0000, busy}, {15'h0000, pending});
			// strobes before power or during a command are dropped
			if (cmd_stb && pon_m && !pending) begin
				apply_cmd();
				pending = 1'b1;
			end else if (done) begin
				if (!pending) begin
					$display("done was seen with no command in progress");
					err_cnt++;
				end else begin
					compare("ar", ar, ar_m);
					compare("nb", {12'h000, nb}, {12'h000, nb_m});
					compare("w", w, w_m);
					compare("alarm", {15'h0000, alarm}, {15'h0000, alarm_m});
				end
				pending = 1'b0;
			end
		end
	end

endmodule

// File: mera_sys.sv
// --------------------
// mera-400 system top
// control panel, bus master, memory and power supply
// joined over the system bus
// --------------------

`timescale 1ns/10ps

module mera_sys (
	input logic clk_ext,
	input logic rst_n,
	input logic cmd_stb,
	input mera_pkg::panel_cmd_t cmd,
	input mera_pkg::word_t kl,
	input mera_pkg::nb_t kl_nb,
	output mera_pkg::word_t w,
	output mera_pkg::addr_t ar,
	output mera_pkg::nb_t nb,
	output logic busy,
	output logic done,
	output logic alarm,
	output logic pon
);

	import mera_pkg::*;

	// panel to master
	logic req, req_wr;
	nb_t req_nb;
	addr_t req_ad;
	word_t req_dt;
	logic cpl, cpl_fault;
	word_t cpl_dt;

	// system bus
	logic dr, dw, rok;
	nb_t dnb;
	addr_t dad;
	word_t ddt, rdt;

	// power supply
	logic clo, dcl;

// --------------------
// power supply
// --------------------

	puks puks_i (
		.clk_ext(clk_ext),
		.rst_n(rst_n),
		.dcl(dcl),
		.pon(pon),
		.clo(clo)
	);

// --------------------
// control panel
// --------------------

	panel_ctl panel_ctl_i (
		.clk_ext(clk_ext),
		.rst_n(rst_n),
		.pon(pon),
		.clo(clo),
		.cmd_stb(cmd_stb),
		.cmd(cmd),
		.kl(kl),
		.kl_nb(kl_nb),
		.req(req),
		.req_wr(req_wr),
		.req_nb(req_nb),
		.req_ad(req_ad),
		.req_dt(req_dt),
		.cpl(cpl),
		.cpl_dt(cpl_dt),
		.cpl_fault(cpl_fault),
		.dcl(dcl),
		.w(w),
		.ar(ar),
		.nb(nb),
		.busy(busy),
		.done(done),
		.alarm(alarm)
	);

// --------------------
// bus and memory
// --------------------

	bus_master bus_master_i (
		.clk_ext(clk_ext),
		.rst_n(rst_n),
		.clo(clo),
		.req(req),
		.req_wr(req_wr),
		.req_nb(req_nb),
		.req_ad(req_ad),
		.req_dt(req_dt),
		.cpl(cpl),
		.cpl_dt(cpl_dt),
		.cpl_fault(cpl_fault),
		.dr(dr),
		.dw(dw),
		.dnb(dnb),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.rdt(rdt)
	);

	mem_ram mem_ram_i (
		.clk_ext(clk_ext),
		.rst_n(rst_n),
		.dr(dr),
		.dw(dw),
		.dnb(dnb),
		.dad(dad),
		.ddt(ddt),
		.rok(rok),
		.rdt(rdt)
	);

endmodule

// File: mem_ram.sv
// --------------------
// bus memory
// MEM_WORDS words in segment 0, answers each
// strobe with ok after a fixed delay
// --------------------

`timescale 1ns/10ps

module mem_ram (
	input logic clk_ext,
	input logic rst_n,
	input logic dr,
	input logic dw,
	input mera_pkg::nb_t dnb,
	input mera_pkg::addr_t dad,
	input mera_pkg::word_t ddt,
	output logic rok,
	output mera_pkg::word_t rdt
);

	import mera_pkg::*;

	word_t mem [MEM_WORDS];
	logic stb;
	logic present;
	logic ok_q;
	tick_t dly;
	logic [MEM_AW-1:0] idx;

	assign stb = dr || dw;
	// segment 0, below the top of memory
	assign present = (dnb == '0) && (dad < addr_t'(MEM_WORDS));
	// low address bits pick the word
	assign idx = dad[16-MEM_AW:15];
	// ok falls together with the strobe
	assign rok = ok_q && stb;

// --------------------
// ok delay
// --------------------

	always_ff @(posedge clk_ext or negedge rst_n) begin
		if (!rst_n) begin
			ok_q <= 1'b0;
			dly <= '0;
		end else if (!stb) begin
			ok_q <= 1'b0;
			dly <= '0;
		end else if (present && !ok_q) begin
			// ok goes up MEM_OK_DLY cycles after the strobe is seen
			if (dly == tick_t'(MEM_OK_DLY))
				ok_q <= 1'b1;
			else
				dly <= dly + tick_t'(1);
		end
	end

	// array access, done once as ok goes up
	always_ff @(posedge clk_ext) begin
		if (stb && present && !ok_q && dly == tick_t'(MEM_OK_DLY)) begin
			if (dw)
				mem[idx] <= ddt;
			else
				rdt <= mem[idx];
		end
	end

	// ok only on a strobe to present memory
	a_ok_in_strobe: assert property (@(posedge clk_ext) disable iff (!rst_n)
		rok |-> stb && present);

endmodule

// File: bus_master.sv
// --------------------
// system bus master
// runs one read or write cycle per request,
// waits for ok or gives up on missing memory
// --------------------

`timescale 1ns/10ps

module bus_master (
	input logic clk_ext,
	input logic rst_n,
	input logic clo,
	input logic req,
	input logic req_wr,
	input mera_pkg::nb_t req_nb,
	input mera_pkg::addr_t req_ad,
	input mera_pkg::word_t req_dt,
	output logic cpl,
	output mera_pkg::word_t cpl_dt,
	output logic cpl_fault,
	output logic dr,
	output logic dw,
	output mera_pkg::nb_t dnb,
	output mera_pkg::addr_t dad,
	output mera_pkg::word_t ddt,
	input logic rok,
	input mera_pkg::word_t rdt
);

	import mera_pkg::*;

	bus_state_t state;
	tick_t tick;
	logic open_cyc;
	logic timeout;

	// strobe is out in these two states
	assign open_cyc = (state == bs_strobe) || (state == bs_wait_ok);
	// no ok within the alarm window
	assign timeout = (tick == tick_t'(ALARM_TICKS - 1));

// --------------------
// cycle fsm
// --------------------

	always_ff @(posedge clk_ext or negedge rst_n) begin
		if (!rst_n) begin
			state <= bs_idle;
			dr <= 1'b0;
			dw <= 1'b0;
			tick <= '0;
			cpl <= 1'b0;
			cpl_fault <= 1'b0;
		end else begin
			cpl <= 1'b0;
			if (clo) begin
				// clear aborts any open cycle
				state <= bs_idle;
				dr <= 1'b0;
				dw <= 1'b0;
				tick <= '0;
			end else begin
				case (state)
					bs_idle: begin
						// one cycle at a time, requests only taken here
						if (req) begin
							dr <= !req_wr;
							dw <= req_wr;
							tick <= '0;
							state <= bs_strobe;
						end
					end
					bs_strobe, bs_wait_ok: begin
						if (rok || timeout) begin
							// drop strobe the cycle after ok
							dr <= 1'b0;
							dw <= 1'b0;
							cpl_fault <= !rok;
							state <= bs_release;
						end else begin
							tick <= tick + tick_t'(1);
							state <= bs_wait_ok;
						end
					end
					bs_release: begin
						// memory drops ok with the strobe
						if (!rok) begin
							cpl <= 1'b1;
							state <= bs_idle;
						end
					end
					default: state <= bs_idle;
				endcase
			end
		end
	end

	// bus payload and read data
	always_ff @(posedge clk_ext) begin
		if (state == bs_idle && req) begin
			dnb <= req_nb;
			dad <= req_ad;
			ddt <= req_dt;
		end
		if (open_cyc && rok)
			cpl_dt <= rdt;
	end

	a_one_strobe: assert property (@(posedge clk_ext) disable iff (!rst_n)
		!(dr && dw));

endmodule

// File: panel_ctl.sv
// --------------------
// control panel
// decodes operator commands, keeps ar, nb and the
// display word, runs store and fetch through the bus master
// --------------------

`timescale 1ns/10ps

module panel_ctl (
	input logic clk_ext,
	input logic rst_n,
	input logic pon,
	input logic clo,
	input logic cmd_stb,
	input mera_pkg::panel_cmd_t cmd,
	input mera_pkg::word_t kl,
	input mera_pkg::nb_t kl_nb,
	output logic req,
	output logic req_wr,
	output mera_pkg::nb_t req_nb,
	output mera_pkg::addr_t req_ad,
	output mera_pkg::word_t req_dt,
	input logic cpl,
	input mera_pkg::word_t cpl_dt,
	input logic cpl_fault,
	output logic dcl,
	output mera_pkg::word_t w,
	output mera_pkg::addr_t ar,
	output mera_pkg::nb_t nb,
	output logic busy,
	output logic done,
	output logic alarm
);

	import mera_pkg::*;

	panel_cmd_t op;
	logic clo_seen;
	logic accept;

	// commands are dropped while busy or before power is good
	assign accept = cmd_stb && pon && !busy;

	always_ff @(posedge clk_ext or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			req <= 1'b0;
			dcl <= 1'b0;
			alarm <= 1'b0;
			ar <= '0;
			nb <= '0;
			w <= '0;
			op <= cmd_load_ar;
			clo_seen <= 1'b0;
		end else begin
			// strobes last one cycle
			req <= 1'b0;
			dcl <= 1'b0;
			done <= 1'b0;
			// done is the last busy cycle
			if (done)
				busy <= 1'b0;
			if (accept) begin
				busy <= 1'b1;
				op <= cmd;
				clo_seen <= 1'b0;
				case (cmd)
					cmd_load_ar: begin
						ar <= kl;
						nb <= kl_nb;
						done <= 1'b1;
					end
					cmd_store, cmd_fetch: req <= 1'b1;
					default: dcl <= 1'b1;
				endcase
			end else if (busy && !done) begin
				case (op)
					cmd_store, cmd_fetch: begin
						if (cpl) begin
							done <= 1'b1;
							// a fault leaves w and ar alone
							if (cpl_fault) begin
								alarm <= 1'b1;
							end else begin
								ar <= ar + addr_t'(1);
								if (op == cmd_fetch)
									w <= cpl_dt;
							end
						end
					end
					cmd_clear: begin
						// wait for the clear pulse to come and go
						if (clo)
							clo_seen <= 1'b1;
						else if (clo_seen)
							done <= 1'b1;
					end
					default: ;
				endcase
			end
			// clear wins over everything, w survives
			if (clo) begin
				ar <= '0;
				nb <= '0;
				alarm <= 1'b0;
			end
		end
	end

	// request payload, sampled with req
	always_ff @(posedge clk_ext) begin
		if (accept) begin
			req_wr <= (cmd == cmd_store);
			req_nb <= nb;
			req_ad <= ar;
			req_dt <= kl;
		end
	end

	a_done_in_busy: assert property (@(posedge clk_ext) disable iff (!rst_n)
		done |-> busy);

endmodule

// File: puks.sv
// --------------------
// power supply sequencer
// holds pon low after reset, then stretches
// panel clear requests into clo pulses
// --------------------

`timescale 1ns/10ps

module puks (
	input logic clk_ext,
	input logic rst_n,
	input logic dcl,
	output logic pon,
	output logic clo
);

	import mera_pkg::*;

	tick_t pon_cnt;
	tick_t clr_cnt;
	logic rcl;

	// merged clear request
	// cpu software clear is not present, so only the panel source is left
	// requests during the power-on hold are already covered by clo
	assign rcl = dcl & pon;

	always_ff @(posedge clk_ext or negedge rst_n) begin
		if (!rst_n) begin
			pon <= 1'b0;
			pon_cnt <= '0;
			clr_cnt <= '0;
		end else begin
			// power-on hold
			if (!pon) begin
				if (pon_cnt == tick_t'(PON_TICKS - 1))
					pon <= 1'b1;
				else
					pon_cnt <= pon_cnt + tick_t'(1);
			end
			// clear pulse stretcher, a new request restarts it
			if (rcl)
				clr_cnt <= tick_t'(CLR_TICKS);
			else if (clr_cnt != '0)
				clr_cnt <= clr_cnt - tick_t'(1);
		end
	end

	// clear during the hold and while the stretcher runs
	assign clo = !pon || (clr_cnt != '0);

	// after the hold, clo only rises in answer to a panel clear
	a_clo_from_dcl: assert property (@(posedge clk_ext) disable iff (!rst_n)
		$rose(clo) |-> pon && $past(dcl));

endmodule

// File: mera_pkg.sv
// --------------------
// mera-400 slice shared definitions
// word and address types, panel and bus enums,
// timing constants for memory, alarm and power supply
// --------------------

package mera_pkg;

	// data word, bit 0 is the msb as on the real machine
	typedef logic [0:15] word_t;
	// word address inside one segment
	typedef logic [0:15] addr_t;
	// memory segment number
	typedef logic [0:3] nb_t;

	// panel commands
	typedef enum logic [1:0] {
		cmd_load_ar,
		cmd_store,
		cmd_fetch,
		cmd_clear
	} panel_cmd_t;

	// bus master cycle states
	typedef enum logic [1:0] {
		bs_idle,
		bs_strobe,
		bs_wait_ok,
		bs_release
	} bus_state_t;

	// memory present, segment 0 only
	localparam int MEM_WORDS = 2048;
	localparam int MEM_AW = $clog2(MEM_WORDS);

	// timing, all in clk_ext cycles
	localparam int MEM_OK_DLY = 3;
	localparam int ALARM_TICKS = 16;
	localparam int PON_TICKS = 8;
	localparam int CLR_TICKS = 4;

	// shared tick counter, wide enough for the longest delay above
	typedef logic [4:0] tick_t;

endpackage
